/* rtl/neoSysPkg.sv */
package neoSysPkg;

	// Host side byte address and register payload
	typedef logic [15:0] hostAddrT;
	typedef logic [15:0] regDataT;

	// Palette index and color word
	typedef logic [7:0] palIdxT;
	typedef logic [15:0] colorT;

	// Bridge FSM, one transaction at a time
	typedef enum logic [1:0] {
		BR_IDLE,
		BR_WRESP,
		BR_RDWAIT,
		BR_RDRESP
	} bridgeStateT;

	// Address windows, sizes are powers of two
	localparam hostAddrT IO_BASE = 16'h0000;
	localparam hostAddrT IO_SIZE = 16'h0100;
	localparam hostAddrT PAL_BASE = 16'h1000;
	localparam hostAddrT PAL_SIZE = 16'h0400;

	// I/O register byte offsets
	localparam hostAddrT REG_P1IN = 16'h0000;
	localparam hostAddrT REG_DIPSW = 16'h0004;
	localparam hostAddrT REG_P2IN = 16'h0008;
	localparam hostAddrT REG_STATUS = 16'h000C;
	localparam hostAddrT REG_SLOT = 16'h0010;
	localparam hostAddrT REG_LED1 = 16'h0014;
	localparam hostAddrT REG_LED2 = 16'h0018;
	localparam hostAddrT REG_POUT = 16'h001C;
	localparam hostAddrT REG_SYSLATCH = 16'h0020;
	localparam hostAddrT REG_COUNT1 = 16'h0040;
	localparam hostAddrT REG_COUNT2 = 16'h0044;
	localparam hostAddrT REG_LOCK1 = 16'h0048;
	localparam hostAddrT REG_LOCK2 = 16'h004C;

	// Coin counter pulse length in clocks
	localparam int COIN_PULSE_LEN = 16;
	localparam int COIN_CNT_W = $clog2(COIN_PULSE_LEN);
	typedef logic [COIN_CNT_W-1:0] coinCntT;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* rtl/hostBridge.sv */
`timescale 1ns/1ps

module hostBridge (
	input  logic clk24M,
	input  logic rst,
	input  neoSysPkg::hostAddrT awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  neoSysPkg::hostAddrT araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic [7:0] regAddr,
	output neoSysPkg::regDataT regWdata,
	output logic ioWe,
	output logic ioRe,
	output logic palWe,
	output logic palRe,
	input  neoSysPkg::regDataT ioRdata,
	input  neoSysPkg::regDataT palRdata
);

	neoSysPkg::bridgeStateT state;
	logic wrFire;
	logic rdFire;
	logic wrIo;
	logic wrPal;
	logic rdIo;
	logic rdPal;
	// Window of the read in flight
	logic rdIsIo;
	logic rdIsPal;
	neoSysPkg::regDataT ioHold;

	// True when address falls in an aligned window
	function automatic logic inWindow(neoSysPkg::hostAddrT a, neoSysPkg::hostAddrT base,
			neoSysPkg::hostAddrT size);
		return (a & ~(size - 16'd1)) == base;
	endfunction

	assign wrIo = inWindow(awaddr, neoSysPkg::IO_BASE, neoSysPkg::IO_SIZE);
	assign wrPal = inWindow(awaddr, neoSysPkg::PAL_BASE, neoSysPkg::PAL_SIZE);
	assign rdIo = inWindow(araddr, neoSysPkg::IO_BASE, neoSysPkg::IO_SIZE);
	assign rdPal = inWindow(araddr, neoSysPkg::PAL_BASE, neoSysPkg::PAL_SIZE);

	// AW and W taken together, writes win over reads
	assign awready = state == neoSysPkg::BR_IDLE;
	assign wready = state == neoSysPkg::BR_IDLE;
	assign arready = (state == neoSysPkg::BR_IDLE) && !(awvalid && wvalid);
	assign wrFire = awvalid && wvalid && awready;
	assign rdFire = arvalid && arready;

	always_ff @(posedge clk24M) begin
		if (rst) begin
			state <= neoSysPkg::BR_IDLE;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			bresp <= neoSysPkg::RESP_OKAY;
			rresp <= neoSysPkg::RESP_OKAY;
			ioWe <= 1'b0;
			ioRe <= 1'b0;
			palWe <= 1'b0;
			palRe <= 1'b0;
			rdIsIo <= 1'b0;
			rdIsPal <= 1'b0;
		end else begin
			// Strobes last a single cycle
			ioWe <= 1'b0;
			ioRe <= 1'b0;
			palWe <= 1'b0;
			palRe <= 1'b0;
			case (state)
				neoSysPkg::BR_IDLE: begin
					if (wrFire) begin
						// Unmapped gets no strobe, only an error
						ioWe <= wrIo;
						palWe <= wrPal;
						bresp <= (wrIo || wrPal) ? neoSysPkg::RESP_OKAY : neoSysPkg::RESP_SLVERR;
						bvalid <= 1'b1;
						state <= neoSysPkg::BR_WRESP;
					end else if (rdFire) begin
						ioRe <= rdIo;
						palRe <= rdPal;
						rdIsIo <= rdIo;
						rdIsPal <= rdPal;
						rresp <= (rdIo || rdPal) ? neoSysPkg::RESP_OKAY : neoSysPkg::RESP_SLVERR;
						state <= neoSysPkg::BR_RDWAIT;
					end
				end
				neoSysPkg::BR_WRESP: begin
					if (bready) begin
						bvalid <= 1'b0;
						state <= neoSysPkg::BR_IDLE;
					end
				end
				// Palette data lands at the end of this cycle
				neoSysPkg::BR_RDWAIT: begin
					rvalid <= 1'b1;
					state <= neoSysPkg::BR_RDRESP;
				end
				neoSysPkg::BR_RDRESP: begin
					if (rready) begin
						rvalid <= 1'b0;
						state <= neoSysPkg::BR_IDLE;
					end
				end
			endcase
		end
	end

	// Register bus address and data, word offset in window
	always_ff @(posedge clk24M) begin
		if (wrFire) begin
			regAddr <= awaddr[9:2];
			regWdata <= wdata[15:0];
		end else if (rdFire) begin
			regAddr <= araddr[9:2];
		end
		// I/O readback is combinational, hold it for the response
		if (state == neoSysPkg::BR_RDWAIT)
			ioHold <= ioRdata;
	end

	// Upper half of the data bus always zero
	assign rdata = {16'h0000, rdIsPal ? palRdata : (rdIsIo ? ioHold : 16'h0000)};

endmodule

/* rtl/ioRegisters.sv */
`timescale 1ns/1ps

module ioRegisters (
	input  logic clk24M,
	input  logic rst,
	input  logic [7:0] regAddr,
	input  neoSysPkg::regDataT regWdata,
	input  logic ioWe,
	input  logic ioRe,
	input  logic [9:0] p1In,
	input  logic [9:0] p2In,
	input  logic [7:0] dipSw,
	input  logic [7:0] statusBits,
	output neoSysPkg::regDataT ioRdata,
	output logic [2:0] slot,
	output logic [7:0] led1,
	output logic [7:0] led2,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic latchWe,
	output logic coinWe,
	output logic [2:0] latchSel,
	output logic latchData
);

	logic offLatch;
	logic offCoin;

	// Eight system latch words, four coin words
	assign offLatch = regAddr[7:3] == neoSysPkg::REG_SYSLATCH[9:5];
	assign offCoin = regAddr[7:2] == neoSysPkg::REG_COUNT1[9:4];

	// Forwarded writes, select from low word bits
	assign latchWe = ioWe && offLatch;
	assign coinWe = ioWe && offCoin;
	assign latchSel = regAddr[2:0];
	assign latchData = regWdata[0];

	// Readback only while the read strobe is up
	always_comb begin
		ioRdata = '0;
		if (ioRe) begin
			case (regAddr)
				neoSysPkg::REG_P1IN[9:2]: ioRdata = {6'b0, p1In};
				neoSysPkg::REG_DIPSW[9:2]: ioRdata = {8'b0, dipSw};
				neoSysPkg::REG_P2IN[9:2]: ioRdata = {6'b0, p2In};
				neoSysPkg::REG_STATUS[9:2]: ioRdata = {8'b0, statusBits};
				// Write-only and unused offsets
				default: ioRdata = '0;
			endcase
		end
	end

	// Output latches, write only
	always_ff @(posedge clk24M) begin
		if (rst) begin
			slot <= '0;
			led1 <= '0;
			led2 <= '0;
			p1Out <= '0;
			p2Out <= '0;
		end else if (ioWe) begin
			case (regAddr)
				neoSysPkg::REG_SLOT[9:2]: slot <= regWdata[2:0];
				neoSysPkg::REG_LED1[9:2]: led1 <= regWdata[7:0];
				neoSysPkg::REG_LED2[9:2]: led2 <= regWdata[7:0];
				// P1 in low three bits, P2 just above
				neoSysPkg::REG_POUT[9:2]: begin
					p1Out <= regWdata[2:0];
					p2Out <= regWdata[5:3];
				end
				default: ;
			endcase
		end
	end

endmodule

/* rtl/sysLatch.sv */
`timescale 1ns/1ps

module sysLatch (
	input  logic clk24M,
	input  logic rst,
	input  logic latchWe,
	input  logic [2:0] latchSel,
	input  logic latchData,
	output logic [7:0] statusBits,
	output logic shadow,
	output logic vecSel,
	output logic cardWrEn,
	output logic regEn,
	output logic sysRom,
	output logic sramLock,
	output logic palBank
);

	logic [7:0] bits;

	// Address picks the bit, data bit 0 its value
	always_ff @(posedge clk24M) begin
		if (rst)
			bits <= '0;
		else if (latchWe)
			bits[latchSel] <= latchData;
	end

	assign statusBits = bits;

	// Bit map
	assign shadow = bits[0];
	assign vecSel = bits[1];
	// Card writes need both enable bits
	assign cardWrEn = bits[2] & bits[3];
	assign regEn = bits[4];
	assign sysRom = bits[5];
	assign sramLock = bits[6];
	assign palBank = bits[7];

endmodule

/* rtl/coinDriver.sv */
`timescale 1ns/1ps

module coinDriver (
	input  logic clk24M,
	input  logic rst,
	input  logic coinWe,
	input  logic [2:0] latchSel,
	input  logic latchData,
	output logic count1,
	output logic count2,
	output logic lock1,
	output logic lock2
);

	neoSysPkg::coinCntT cnt [2];
	logic [1:0] hit;

	// Channel 0 and 1 are the counters, 2 and 3 the lockouts
	assign hit[0] = coinWe && (latchSel == 3'd0);
	assign hit[1] = coinWe && (latchSel == 3'd1);

	// Pulse starts on the strobe itself, counter covers the rest
	assign count1 = hit[0] || (cnt[0] != '0);
	assign count2 = hit[1] || (cnt[1] != '0);

	always_ff @(posedge clk24M) begin
		if (rst) begin
			cnt[0] <= '0;
			cnt[1] <= '0;
			lock1 <= 1'b0;
			lock2 <= 1'b0;
		end else begin
			// Any counter write fires or restarts the pulse
			for (int i = 0; i < 2; i++) begin
				if (hit[i])
					cnt[i] <= neoSysPkg::coinCntT'(neoSysPkg::COIN_PULSE_LEN - 1);
				else if (cnt[i] != '0)
					cnt[i] <= cnt[i] - 1'b1;
			end
			// Lockout levels follow data bit 0
			if (coinWe && (latchSel == 3'd2))
				lock1 <= latchData;
			if (coinWe && (latchSel == 3'd3))
				lock2 <= latchData;
		end
	end

endmodule

/* rtl/paletteRam.sv */
`timescale 1ns/1ps

module paletteRam (
	input  logic clk24M,
	input  logic [7:0] regAddr,
	input  neoSysPkg::regDataT regWdata,
	input  logic palWe,
	input  logic palRe,
	input  logic palBank,
	output neoSysPkg::regDataT palRdata,
	input  neoSysPkg::palIdxT videoIdx,
	output neoSysPkg::colorT colorOut
);

	// Two banks of 256 colors
	neoSysPkg::colorT mem [512];
	logic [8:0] hostIdx;
	logic [8:0] vidIdx;

	// Bank bit on top for both ports
	assign hostIdx = {palBank, regAddr};
	assign vidIdx = {palBank, videoIdx};

	// Host port, read data held until the next read
	always_ff @(posedge clk24M) begin
		if (palWe)
			mem[hostIdx] <= regWdata;
		if (palRe)
			palRdata <= mem[hostIdx];
	end

	// Video port, one cycle latency
	always_ff @(posedge clk24M) begin
		colorOut <= mem[vidIdx];
	end

endmodule

/* rtl/neoSysIo.sv */
`timescale 1ns/1ps

module neoSysIo (
	input  logic clk24M,
	input  logic rst,
	input  neoSysPkg::hostAddrT awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  neoSysPkg::hostAddrT araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic [9:0] p1In,
	input  logic [9:0] p2In,
	input  logic [7:0] dipSw,
	output logic [2:0] slot,
	output logic [7:0] led1,
	output logic [7:0] led2,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic count1,
	output logic count2,
	output logic lock1,
	output logic lock2,
	output logic shadow,
	output logic sysRom,
	output logic palBank,
	input  neoSysPkg::palIdxT videoIdx,
	output neoSysPkg::colorT colorOut
);

	// Internal register bus
	logic [7:0] regAddr;
	neoSysPkg::regDataT regWdata;
	logic ioWe;
	logic ioRe;
	logic palWe;
	logic palRe;
	neoSysPkg::regDataT ioRdata;
	neoSysPkg::regDataT palRdata;

	// F0 to latch and coin driver
	logic [7:0] statusBits;
	logic latchWe;
	logic coinWe;
	logic [2:0] latchSel;
	logic latchData;

	hostBridge i_hostBridge (
		.clk24M, .rst,
		.awaddr, .awvalid, .awready,
		.wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.regAddr, .regWdata,
		.ioWe, .ioRe, .palWe, .palRe,
		.ioRdata, .palRdata
	);

	ioRegisters i_ioRegisters (
		.clk24M, .rst,
		.regAddr, .regWdata, .ioWe, .ioRe,
		.p1In, .p2In, .dipSw, .statusBits,
		.ioRdata,
		.slot, .led1, .led2, .p1Out, .p2Out,
		.latchWe, .coinWe, .latchSel, .latchData
	);

	// Vector, card, register and SRAM bits stay internal
	sysLatch i_sysLatch (
		.clk24M, .rst,
		.latchWe, .latchSel, .latchData,
		.statusBits,
		.shadow, .vecSel(), .cardWrEn(), .regEn(), .sysRom, .sramLock(), .palBank
	);

	coinDriver i_coinDriver (
		.clk24M, .rst,
		.coinWe, .latchSel, .latchData,
		.count1, .count2, .lock1, .lock2
	);

	paletteRam i_paletteRam (
		.clk24M,
		.regAddr, .regWdata, .palWe, .palRe, .palBank,
		.palRdata,
		.videoIdx, .colorOut
	);

endmodule

/* verification/neoSysIoTb.sv */
`timescale 1ns/1ps

module neoSysIoTb;

	// About 120 bus transfers of under ten cycles each plus coin pulse waits and margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [31:0] LFSR_SEED = 32'd96676;
	localparam logic [31:0] LFSR_TAPS = 32'hA3000000;

	logic clk24M;
	logic rst;
	neoSysPkg::hostAddrT awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	neoSysPkg::hostAddrT araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic [7:0] dipSw;
	logic [2:0] slot;
	logic [7:0] led1;
	logic [7:0] led2;
	logic [2:0] p1Out;
	logic [2:0] p2Out;
	logic count1;
	logic count2;
	logic lock1;
	logic lock2;
	logic shadow;
	logic sysRom;
	logic palBank;
	neoSysPkg::palIdxT videoIdx;
	neoSysPkg::colorT colorOut;

	int mismatches;
	int failures;
	int cycles;
	logic [31:0] lfsrState;

	// Reference model of the visible state
	logic wrHs;
	logic arHs;
	logic wrPend;
	neoSysPkg::hostAddrT pendAddr;
	neoSysPkg::regDataT pendData;
	logic [2:0] expSlot;
	logic [7:0] expLed1;
	logic [7:0] expLed2;
	logic [2:0] expP1Out;
	logic [2:0] expP2Out;
	logic [7:0] expBits;
	logic expLock1;
	logic expLock2;
	int remain1;
	int remain2;
	neoSysPkg::colorT expPal [512];
	logic palKnown [512];
	neoSysPkg::colorT expColor;
	logic expColorKnown;

	neoSysIo i_neoSysIo (.*);

	always #5 clk24M = ~clk24M;

	assign wrHs = awvalid && wvalid && awready && wready;
	assign arHs = arvalid && arready;

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		mismatches++;
		$display("MISMATCH %s: got %h, expected %h", name, got, want);
	endtask

	task automatic reportFailure(input string msg);
		failures++;
		$display("ERROR %s", msg);
	endtask

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r[i] = lfsrState[0];
			lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? LFSR_TAPS : 32'h0);
		end
		return r;
	endfunction

	function automatic logic inIo(input neoSysPkg::hostAddrT a);
		return neoSysPkg::hostAddrT'(a - neoSysPkg::IO_BASE) < neoSysPkg::IO_SIZE;
	endfunction

	function automatic logic inPal(input neoSysPkg::hostAddrT a);
		return neoSysPkg::hostAddrT'(a - neoSysPkg::PAL_BASE) < neoSysPkg::PAL_SIZE;
	endfunction

	function automatic neoSysPkg::hostAddrT ioAddr(input neoSysPkg::hostAddrT off);
		return neoSysPkg::IO_BASE + off;
	endfunction

	function automatic neoSysPkg::hostAddrT palAddr(input neoSysPkg::palIdxT idx);
		return neoSysPkg::PAL_BASE + neoSysPkg::hostAddrT'({idx, 2'b00});
	endfunction

	// Zero-extended inputs and status in the I/O window
	function automatic logic [31:0] expectedIoRead(input neoSysPkg::hostAddrT a);
		neoSysPkg::hostAddrT off;
		off = a - neoSysPkg::IO_BASE;
		case (off)
			neoSysPkg::REG_P1IN: return {22'h0, p1In};
			neoSysPkg::REG_DIPSW: return {24'h0, dipSw};
			neoSysPkg::REG_P2IN: return {22'h0, p2In};
			neoSysPkg::REG_STATUS: return {24'h0, expBits};
			default: return 32'h0;
		endcase
	endfunction

	// Model writes take effect on the strobe edge
	always @(posedge clk24M) begin
		neoSysPkg::hostAddrT off;
		neoSysPkg::hostAddrT palOff;
		off = pendAddr - neoSysPkg::IO_BASE;
		palOff = pendAddr - neoSysPkg::PAL_BASE;
		if (rst) begin
			wrPend <= 1'b0;
			expSlot <= '0;
			expLed1 <= '0;
			expLed2 <= '0;
			expP1Out <= '0;
			expP2Out <= '0;
			expBits <= '0;
			expLock1 <= 1'b0;
			expLock2 <= 1'b0;
			remain1 <= 0;
			remain2 <= 0;
			expColorKnown <= 1'b0;
		end else begin
			wrPend <= wrHs;
			pendAddr <= awaddr;
			pendData <= wdata[15:0];
			// Pulse length counted from the handshake
			// First high cycle is the strobe
			if (wrHs && awaddr == ioAddr(neoSysPkg::REG_COUNT1))
				remain1 <= neoSysPkg::COIN_PULSE_LEN;
			else if (remain1 > 0)
				remain1 <= remain1 - 1;
			if (wrHs && awaddr == ioAddr(neoSysPkg::REG_COUNT2))
				remain2 <= neoSysPkg::COIN_PULSE_LEN;
			else if (remain2 > 0)
				remain2 <= remain2 - 1;
			if (wrPend && inIo(pendAddr)) begin
				case (off)
					neoSysPkg::REG_SLOT: expSlot <= pendData[2:0];
					neoSysPkg::REG_LED1: expLed1 <= pendData[7:0];
					neoSysPkg::REG_LED2: expLed2 <= pendData[7:0];
					neoSysPkg::REG_POUT: begin
						expP1Out <= pendData[2:0];
						expP2Out <= pendData[5:3];
					end
					neoSysPkg::REG_LOCK1: expLock1 <= pendData[0];
					neoSysPkg::REG_LOCK2: expLock2 <= pendData[0];
					default: begin
						// Eight latch words with one bit each
						if (off >= neoSysPkg::REG_SYSLATCH &&
								off < neoSysPkg::REG_SYSLATCH + 16'h20)
							expBits[off[4:2]] <= pendData[0];
					end
				endcase
			end
			if (wrPend && inPal(pendAddr)) begin
				expPal[{expBits[7], palOff[9:2]}] <= pendData;
				palKnown[{expBits[7], palOff[9:2]}] <= 1'b1;
			end
			// Video port sees the bank and memory before this edge
			expColor <= expPal[{expBits[7], videoIdx}];
			expColorKnown <= palKnown[{expBits[7], videoIdx}];
		end
	end

	// Outputs against the model
	assert property (@(posedge clk24M) disable iff (rst) slot == expSlot)
		else reportMismatch("slot", slot, expSlot);
	assert property (@(posedge clk24M) disable iff (rst) led1 == expLed1)
		else reportMismatch("led1", led1, expLed1);
	assert property (@(posedge clk24M) disable iff (rst) led2 == expLed2)
		else reportMismatch("led2", led2, expLed2);
	assert property (@(posedge clk24M) disable iff (rst) p1Out == expP1Out)
		else reportMismatch("p1Out", p1Out, expP1Out);
	assert property (@(posedge clk24M) disable iff (rst) p2Out == expP2Out)
		else reportMismatch("p2Out", p2Out, expP2Out);
	assert property (@(posedge clk24M) disable iff (rst) shadow == expBits[0])
		else reportMismatch("shadow", shadow, expBits[0]);
	assert property (@(posedge clk24M) disable iff (rst) sysRom == expBits[5])
		else reportMismatch("sysRom", sysRom, expBits[5]);
	assert property (@(posedge clk24M) disable iff (rst) palBank == expBits[7])
		else reportMismatch("palBank", palBank, expBits[7]);
	assert property (@(posedge clk24M) disable iff (rst) count1 == (remain1 != 0))
		else reportMismatch("count1", count1, remain1 != 0);
	assert property (@(posedge clk24M) disable iff (rst) count2 == (remain2 != 0))
		else reportMismatch("count2", count2, remain2 != 0);
	assert property (@(posedge clk24M) disable iff (rst) lock1 == expLock1)
		else reportMismatch("lock1", lock1, expLock1);
	assert property (@(posedge clk24M) disable iff (rst) lock2 == expLock2)
		else reportMismatch("lock2", lock2, expLock2);
	assert property (@(posedge clk24M) disable iff (rst) expColorKnown |-> colorOut == expColor)
		else reportMismatch("colorOut", colorOut, expColor);

	// Handshake timing and back-pressure
	assert property (@(posedge clk24M) $fell(rst) |->
			awready && wready && arready && !bvalid && !rvalid)
		else reportFailure("ready or valid signals wrong after reset");
	assert property (@(posedge clk24M) disable iff (rst) wrHs |=> bvalid)
		else reportFailure("bvalid did not rise the cycle after the write handshake");
	assert property (@(posedge clk24M) disable iff (rst)
			bvalid && !bready |=> bvalid && $stable(bresp))
		else reportFailure("write response dropped or changed while bready was low");
	assert property (@(posedge clk24M) disable iff (rst) bvalid |-> !awready && !wready)
		else reportFailure("write accepted while a write response was pending");
	assert property (@(posedge clk24M) disable iff (rst) arHs |=> !rvalid)
		else reportFailure("rvalid rose one cycle after the read handshake");
	assert property (@(posedge clk24M) disable iff (rst) $past(arHs, 2) |-> rvalid)
		else reportFailure("rvalid did not rise two cycles after the read handshake");
	assert property (@(posedge clk24M) disable iff (rst)
			rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else reportFailure("read response dropped or changed while rready was low");
	assert property (@(posedge clk24M) disable iff (rst) rvalid |-> !arready)
		else reportFailure("read accepted while a read response was pending");

	// Full-word write with bready held low for hold cycles once bvalid is up
	task automatic axiWrite(input neoSysPkg::hostAddrT addr, input logic [31:0] data,
			input int hold);
		logic [1:0] wantResp;
		wantResp = (inIo(addr) || inPal(addr)) ? neoSysPkg::RESP_OKAY : neoSysPkg::RESP_SLVERR;
		@(posedge clk24M);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		bready <= (hold == 0);
		do @(posedge clk24M); while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do @(posedge clk24M); while (!bvalid);
		assert (bresp == wantResp) else reportMismatch("bresp", bresp, wantResp);
		if (hold > 0) begin
			repeat (hold) @(posedge clk24M);
			bready <= 1'b1;
			@(posedge clk24M);
		end
	endtask

	task automatic axiRead(input neoSysPkg::hostAddrT addr, input int hold);
		logic [31:0] want;
		logic [1:0] wantResp;
		logic checkData;
		neoSysPkg::hostAddrT palOff;
		logic [8:0] pIdx;
		@(posedge clk24M);
		// Expected values taken after earlier writes have settled
		palOff = addr - neoSysPkg::PAL_BASE;
		pIdx = {expBits[7], palOff[9:2]};
		wantResp = (inIo(addr) || inPal(addr)) ? neoSysPkg::RESP_OKAY : neoSysPkg::RESP_SLVERR;
		want = expectedIoRead(addr);
		checkData = 1'b1;
		if (inPal(addr)) begin
			want = {16'h0, expPal[pIdx]};
			checkData = palKnown[pIdx];
		end else if (!inIo(addr)) begin
			want = 32'h0;
		end
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= (hold == 0);
		do @(posedge clk24M); while (!arready);
		arvalid <= 1'b0;
		do @(posedge clk24M); while (!rvalid);
		assert (rresp == wantResp) else reportMismatch("rresp", rresp, wantResp);
		if (checkData)
			assert (rdata == want) else reportMismatch("rdata", rdata, want);
		if (hold > 0) begin
			repeat (hold) @(posedge clk24M);
			rready <= 1'b1;
			@(posedge clk24M);
		end
	endtask

	task automatic setLatchBit(input int bitIdx, input logic value);
		axiWrite(ioAddr(neoSysPkg::REG_SYSLATCH + neoSysPkg::hostAddrT'(bitIdx * 4)),
			{31'h0, value}, 0);
	endtask

	task automatic showColor(input neoSysPkg::palIdxT idx);
		@(posedge clk24M);
		videoIdx <= idx;
		repeat (3) @(posedge clk24M);
	endtask

	// Hard stop if the sequence stalls
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk24M);
			cycles++;
		end
		reportFailure("timeout, the test sequence did not finish");
		$display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		neoSysPkg::palIdxT idx;
		neoSysPkg::colorT c0;
		neoSysPkg::colorT c1;
		mismatches = 0;
		failures = 0;
		lfsrState = LFSR_SEED;
		for (int i = 0; i < 512; i++)
			palKnown[i] = 1'b0;
		clk24M = 1'b0;
		rst <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b1;
		p1In <= '0;
		p2In <= '0;
		dipSw <= '0;
		videoIdx <= '0;
		repeat (10) @(posedge clk24M);
		rst <= 1'b0;
		repeat (2) @(posedge clk24M);

		// Input readback and unused offsets
		repeat (4) begin
			@(posedge clk24M);
			p1In <= 10'(randBits(10));
			p2In <= 10'(randBits(10));
			dipSw <= 8'(randBits(8));
			axiRead(ioAddr(neoSysPkg::REG_P1IN), 0);
			axiRead(ioAddr(neoSysPkg::REG_DIPSW), 0);
			axiRead(ioAddr(neoSysPkg::REG_P2IN), 0);
		end
		axiRead(ioAddr(neoSysPkg::REG_SLOT), 0);
		axiRead(ioAddr(16'h0050), 0);
		axiRead(ioAddr(16'h00FC), 0);

		// Output latches with unrelated writes in between
		repeat (4) begin
			axiWrite(ioAddr(neoSysPkg::REG_SLOT), randBits(16), 0);
			axiWrite(ioAddr(neoSysPkg::REG_LED1), randBits(16), 0);
			axiWrite(ioAddr(neoSysPkg::REG_LED2), randBits(16), 0);
			axiWrite(ioAddr(neoSysPkg::REG_POUT), randBits(16), 0);
			axiWrite(ioAddr(16'h0060), randBits(16), 0);
		end

		// Each system latch word alone and then all set and cleared
		for (int i = 0; i < 8; i++) begin
			setLatchBit(i, 1'(randBits(1)));
			axiRead(ioAddr(neoSysPkg::REG_STATUS), 0);
		end
		for (int i = 0; i < 8; i++)
			setLatchBit(i, 1'b1);
		axiRead(ioAddr(neoSysPkg::REG_STATUS), 0);
		for (int i = 7; i >= 0; i--) begin
			setLatchBit(i, 1'b0);
			axiRead(ioAddr(neoSysPkg::REG_STATUS), 0);
		end

		// Same index with a different word per bank
		repeat (4) begin
			idx = 8'(randBits(8));
			c0 = 16'(randBits(16));
			c1 = 16'(randBits(16));
			if (c1 == c0)
				c1 = ~c0;
			setLatchBit(7, 1'b0);
			axiWrite(palAddr(idx), {16'h0, c0}, 0);
			setLatchBit(7, 1'b1);
			axiWrite(palAddr(idx), {16'h0, c1}, 0);
			axiRead(palAddr(idx), 0);
			showColor(idx);
			setLatchBit(7, 1'b0);
			axiRead(palAddr(idx), 0);
			showColor(idx);
		end

		// Single coin pulse and one restarted mid-pulse
		axiWrite(ioAddr(neoSysPkg::REG_COUNT1), randBits(16), 0);
		repeat (neoSysPkg::COIN_PULSE_LEN + 4) @(posedge clk24M);
		axiWrite(ioAddr(neoSysPkg::REG_COUNT1), randBits(16), 0);
		repeat (6) @(posedge clk24M);
		axiWrite(ioAddr(neoSysPkg::REG_COUNT1), randBits(16), 0);
		repeat (neoSysPkg::COIN_PULSE_LEN + 4) @(posedge clk24M);
		axiWrite(ioAddr(neoSysPkg::REG_COUNT2), randBits(16), 0);
		repeat (neoSysPkg::COIN_PULSE_LEN + 4) @(posedge clk24M);
		axiWrite(ioAddr(neoSysPkg::REG_LOCK1), 32'h1, 0);
		axiWrite(ioAddr(neoSysPkg::REG_LOCK2), 32'h1, 0);
		axiWrite(ioAddr(neoSysPkg::REG_LOCK1), 32'h0, 0);
		axiWrite(ioAddr(neoSysPkg::REG_LOCK2), randBits(1), 0);

		// Unmapped accesses whose low bits alias writable latches
		axiWrite(16'h2014, randBits(16), 0);
		axiWrite(16'h0818, randBits(16), 0);
		axiRead(16'h2000, 0);
		axiRead(16'h0800, 0);
		// Held responses
		axiWrite(ioAddr(neoSysPkg::REG_LED2), randBits(16), 5);
		axiWrite(16'h201C, randBits(16), 3);
		axiRead(ioAddr(neoSysPkg::REG_P1IN), 4);
		repeat (4) @(posedge clk24M);

		$display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* files.f */
rtl/neoSysPkg.sv
rtl/hostBridge.sv
rtl/ioRegisters.sv
rtl/sysLatch.sv
rtl/coinDriver.sv
rtl/paletteRam.sv
rtl/neoSysIo.sv
verification/neoSysIoTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= neoSysIoTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -Wno-fatal
PASS_MSG ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
